/* include/mac_rx_config.svh */
//////////////////////////////
// Build parameters of the MII receive path.
// FIFO depth and frame length counter width.
//////////////////////////////

`ifndef MAC_RX_CONFIG_SVH
`define MAC_RX_CONFIG_SVH

//////////////////////////////
// Entry FIFO
//////////////////////////////

// Base-2 log of the FIFO depth.
// 4 gives 16 entries.
`define RX_FIFO_DEPTH_LOG2 4

//////////////////////////////
// Frame statistics
//////////////////////////////

// Width of the byte counter after the delimiter.
// 11 bits covers a full-size frame with FCS.
`define RX_LEN_WIDTH 11

`endif

/* design/mii_pkg.sv */
//////////////////////////////
// PHY-side types of the receive path.
// Nibble, octet and FIFO entry.
//////////////////////////////

package mii_pkg;

	// One MII data nibble.
	typedef logic [3:0] nibble_t;

	// One assembled octet, low nibble first on the wire.
	typedef logic [7:0] byte_t;

	// One FIFO entry.
	// eof = 0: data is a frame byte.
	// eof = 1: data[0] is the frame error flag.
	// eof = 1: data[1] is set when the error came from an odd nibble count.
	// Remaining bits are zero on an end-of-frame entry.
	typedef struct packed {
		logic  eof;
		byte_t data;
	} rx_entry_t;

	// Bit positions inside an end-of-frame entry.
	localparam int eof_err_bit = 0;
	localparam int eof_odd_bit = 1;

endpackage

/* design/frame_pkg.sv */
//////////////////////////////
// Frame-level types.
// Length, CRC word, status word, FSM states.
//////////////////////////////

`include "mac_rx_config.svh"

package frame_pkg;

	// Bytes after the delimiter, FCS included.
	typedef logic [`RX_LEN_WIDTH-1:0] frame_len_t;

	// CRC-32 register value.
	typedef logic [31:0] crc_t;

	//////////////////////////////
	// Per-frame status word
	//////////////////////////////

	// Captured once per frame on the end-of-frame entry.
	typedef struct packed {
		frame_len_t length;
		logic       crc_ok;
		logic       phy_err;
		logic       odd_nibble;
		logic       overflow;
	} frame_status_t;

	//////////////////////////////
	// Statistics FSM
	//////////////////////////////

	// Idle until a byte shows up.
	// Preamble until the delimiter.
	// Payload until end of frame.
	typedef enum logic [1:0] {
		st_idle,
		st_preamble,
		st_payload
	} stats_state_t;

endpackage

/* design/rx_crc32.sv */
//////////////////////////////
// Byte-wide Ethernet CRC-32 checker.
//////////////////////////////

`timescale 1ns/1ps

module rx_crc32 (
	input  logic           phy_rx_clk,
	input  logic           rx_rst2,
	input  logic           clear,
	input  logic           en,
	input  mii_pkg::byte_t data,
	output logic           residue_ok
);

	// Reflected generator polynomial.
	localparam frame_pkg::crc_t crc_poly    = 32'hEDB88320;
	// Good-frame residue, MSB-first form.
	localparam frame_pkg::crc_t crc_residue = 32'hC704DD7B;

	frame_pkg::crc_t crc_q;
	frame_pkg::crc_t crc_msb_first;

	// One octet, least significant bit first.
	function automatic frame_pkg::crc_t crc_byte(input frame_pkg::crc_t c,
		input mii_pkg::byte_t d);
		frame_pkg::crc_t r;
		r = c;
		for (int i = 0; i < 8; i++) begin
			r = (r >> 1) ^ (crc_poly & {32{r[0] ^ d[i]}});
		end
		return r;
	endfunction

	always_ff @(posedge phy_rx_clk) begin
		if (rx_rst2 || clear) begin
			crc_q <= '1;
		end else if (en) begin
			crc_q <= crc_byte(crc_q, data);
		end
	end

	// Register is bit-reversed against the residue constant.
	assign crc_msb_first = {<<{crc_q}};
	assign residue_ok    = (crc_msb_first == crc_residue);

endmodule

/* design/mii_nibble_packer.sv */
//////////////////////////////
// MII nibble to byte packer.
// Emits end-of-frame entries with error flags.
//////////////////////////////

`timescale 1ns/1ps

module mii_nibble_packer (
	input  logic               phy_rx_clk,
	input  logic               rx_rst2,
	input  mii_pkg::nibble_t   phy_rx_data,
	input  logic               phy_dv,
	input  logic               phy_rx_er,
	output mii_pkg::rx_entry_t wr_entry,
	output logic               wr_en
);

	// Low nibble waiting for its partner.
	mii_pkg::nibble_t lo_nibble;
	// Next nibble is the high half.
	logic hi_nibble;
	// Delayed data valid, for the falling edge.
	logic phy_dv_r;
	// PHY error seen somewhere in this frame.
	logic err_seen;
	logic dv_fall;

	// End of frame, first sample with phy_dv low.
	assign dv_fall = phy_dv_r & ~phy_dv;

	//////////////////////////////
	// Control
	//////////////////////////////

	always_ff @(posedge phy_rx_clk) begin
		if (rx_rst2) begin
			wr_en     <= 1'b0;
			hi_nibble <= 1'b0;
			phy_dv_r  <= 1'b0;
			err_seen  <= 1'b0;
		end else begin
			wr_en    <= 1'b0;
			phy_dv_r <= phy_dv;
			if (phy_dv) begin
				// Toggle halves, write after the high one.
				hi_nibble <= ~hi_nibble;
				wr_en     <= hi_nibble;
				if (phy_rx_er) begin
					err_seen <= 1'b1;
				end
			end
			if (dv_fall) begin
				// One end-of-frame write, then start clean.
				wr_en     <= 1'b1;
				hi_nibble <= 1'b0;
				err_seen  <= 1'b0;
			end
		end
	end

	//////////////////////////////
	// Entry payload
	//////////////////////////////

	always_ff @(posedge phy_rx_clk) begin
		if (phy_dv && !hi_nibble) begin
			lo_nibble <= phy_rx_data;
		end
		if (phy_dv && hi_nibble) begin
			wr_entry.eof  <= 1'b0;
			wr_entry.data <= {phy_rx_data, lo_nibble};
		end
		if (dv_fall) begin
			// A pending low nibble means an odd count; it is dropped.
			wr_entry.eof                       <= 1'b1;
			wr_entry.data                      <= '0;
			wr_entry.data[mii_pkg::eof_err_bit] <= err_seen | hi_nibble;
			wr_entry.data[mii_pkg::eof_odd_bit] <= hi_nibble;
		end
	end

endmodule

/* design/rx_entry_fifo.sv */
//////////////////////////////
// Single-clock show-ahead entry FIFO.
// Full level and drop pulse on refused writes.
//////////////////////////////

`timescale 1ns/1ps

`include "mac_rx_config.svh"

module rx_entry_fifo (
	input  logic               phy_rx_clk,
	input  logic               rx_rst2,
	input  mii_pkg::rx_entry_t wr_entry,
	input  logic               wr_en,
	output mii_pkg::rx_entry_t rd_entry,
	output logic               empty,
	input  logic               ack,
	output logic               full,
	output logic               drop
);

	localparam int addr_w = `RX_FIFO_DEPTH_LOG2;
	localparam int depth  = 1 << addr_w;

	mii_pkg::rx_entry_t mem [depth];

	// Pointers carry one extra wrap bit.
	logic [addr_w:0] wr_ptr;
	logic [addr_w:0] rd_ptr;
	// Write pointer as seen by the read side, one cycle late.
	logic [addr_w:0] wr_ptr_vis;
	logic            do_write;
	logic            do_read;

	// Same address, different wrap bit.
	assign full = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
		(wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);
	assign empty = (wr_ptr_vis == rd_ptr);

	assign do_write = wr_en & ~full;
	// Pop while empty is ignored.
	assign do_read  = ack & ~empty;
	// Refused write, one pulse per lost entry.
	assign drop     = wr_en & full;

	// Head entry shown ahead of the pop.
	assign rd_entry = mem[rd_ptr[addr_w-1:0]];

	//////////////////////////////
	// Storage
	//////////////////////////////

	always_ff @(posedge phy_rx_clk) begin
		if (do_write) begin
			mem[wr_ptr[addr_w-1:0]] <= wr_entry;
		end
	end

	//////////////////////////////
	// Pointers
	//////////////////////////////

	always_ff @(posedge phy_rx_clk) begin
		if (rx_rst2) begin
			wr_ptr     <= '0;
			wr_ptr_vis <= '0;
			rd_ptr     <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			// New entry goes visible one edge after its write.
			wr_ptr_vis <= wr_ptr;
			if (do_read) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

endmodule

/* design/rx_frame_stats.sv */
//////////////////////////////
// Per-frame statistics.
// Preamble strip, length, CRC check, status pulse.
//////////////////////////////

`timescale 1ns/1ps

module rx_frame_stats (
	input  logic                     phy_rx_clk,
	input  logic                     rx_rst2,
	input  mii_pkg::rx_entry_t       wr_entry,
	input  logic                     wr_en,
	input  logic                     drop,
	output frame_pkg::frame_status_t frame_status,
	output logic                     frame_done
);

	localparam mii_pkg::byte_t sfd_byte = 8'hD5;

	frame_pkg::stats_state_t state;
	frame_pkg::frame_len_t   len_cnt;
	// Some entry of this frame was lost.
	logic ovf_seen;
	logic is_data;
	logic is_eof;
	logic is_sfd;
	logic crc_en;
	logic residue_ok;

	// Strobe decode.
	assign is_data = wr_en & ~wr_entry.eof;
	assign is_eof  = wr_en & wr_entry.eof;
	// Delimiter only counts before the payload.
	assign is_sfd  = is_data && (wr_entry.data == sfd_byte) &&
		(state != frame_pkg::st_payload);
	// Every byte after the delimiter, FCS included.
	assign crc_en  = is_data && (state == frame_pkg::st_payload);

	rx_crc32 crc_i (
		.phy_rx_clk (phy_rx_clk),
		.rx_rst2    (rx_rst2),
		.clear      (is_sfd),
		.en         (crc_en),
		.data       (wr_entry.data),
		.residue_ok (residue_ok)
	);

	//////////////////////////////
	// FSM
	//////////////////////////////

	always_ff @(posedge phy_rx_clk) begin
		if (rx_rst2) begin
			state <= frame_pkg::st_idle;
		end else if (is_eof) begin
			state <= frame_pkg::st_idle;
		end else if (is_data) begin
			case (state)
				frame_pkg::st_idle: begin
					// A frame may start right on the delimiter.
					state <= is_sfd ? frame_pkg::st_payload : frame_pkg::st_preamble;
				end
				frame_pkg::st_preamble: begin
					if (is_sfd) begin
						state <= frame_pkg::st_payload;
					end
				end
				default: begin
					state <= frame_pkg::st_payload;
				end
			endcase
		end
	end

	//////////////////////////////
	// Counters and flags
	//////////////////////////////

	always_ff @(posedge phy_rx_clk) begin
		if (rx_rst2) begin
			len_cnt    <= '0;
			ovf_seen   <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= is_eof;
			if (is_sfd) begin
				len_cnt <= '0;
			end else if (crc_en) begin
				len_cnt <= len_cnt + 1'b1;
			end
			// Drops are remembered until end of frame.
			if (is_eof) begin
				ovf_seen <= 1'b0;
			end else if (drop) begin
				ovf_seen <= 1'b1;
			end
		end
	end

	// Status capture on the end-of-frame entry.
	// A dropped end-of-frame entry still counts as overflow.
	always_ff @(posedge phy_rx_clk) begin
		if (is_eof) begin
			frame_status.length     <= len_cnt;
			frame_status.crc_ok     <= residue_ok && (state == frame_pkg::st_payload);
			frame_status.phy_err    <= wr_entry.data[mii_pkg::eof_err_bit] &
				~wr_entry.data[mii_pkg::eof_odd_bit];
			frame_status.odd_nibble <= wr_entry.data[mii_pkg::eof_odd_bit];
			frame_status.overflow   <= ovf_seen | drop;
		end
	end

endmodule

/* design/mac_rx_top.sv */
//////////////////////////////
// MII receive path top level.
// Packer, entry FIFO, frame statistics.
//////////////////////////////

`timescale 1ns/1ps

module mac_rx_top (
	input  logic                     phy_rx_clk,
	input  logic                     rx_rst2,

	// MII receive pins.
	input  mii_pkg::nibble_t         phy_rx_data,
	input  logic                     phy_dv,
	input  logic                     phy_rx_er,

	// Consumer side.
	output mii_pkg::rx_entry_t       rd_entry,
	output logic                     empty,
	input  logic                     ack,
	output logic                     fifo_full,

	// One status word per frame.
	output frame_pkg::frame_status_t frame_status,
	output logic                     frame_done
);

	// Write stream, shared by FIFO and statistics.
	mii_pkg::rx_entry_t wr_entry;
	logic               wr_en;
	// Lost entry.
	logic               drop;

	mii_nibble_packer packer_i (
		.phy_rx_clk  (phy_rx_clk),
		.rx_rst2     (rx_rst2),
		.phy_rx_data (phy_rx_data),
		.phy_dv      (phy_dv),
		.phy_rx_er   (phy_rx_er),
		.wr_entry    (wr_entry),
		.wr_en       (wr_en)
	);

	rx_entry_fifo fifo_i (
		.phy_rx_clk (phy_rx_clk),
		.rx_rst2    (rx_rst2),
		.wr_entry   (wr_entry),
		.wr_en      (wr_en),
		.rd_entry   (rd_entry),
		.empty      (empty),
		.ack        (ack),
		.full       (fifo_full),
		.drop       (drop)
	);

	rx_frame_stats stats_i (
		.phy_rx_clk   (phy_rx_clk),
		.rx_rst2      (rx_rst2),
		.wr_entry     (wr_entry),
		.wr_en        (wr_en),
		.drop         (drop),
		.frame_status (frame_status),
		.frame_done   (frame_done)
	);

endmodule

/* tb/tb_mac_rx.sv */
//////////////////////////////
// Testbench for the MII receive path.
// Frame driver, reference model, consumer, checks.
//////////////////////////////

`timescale 1ns/1ps

`include "mac_rx_config.svh"

module tb_mac_rx;

	// Payload sizes of the frames in send order.
	localparam int n_frames = 6;
	localparam int payload_lens [n_frames] = '{10, 12, 8, 9, 40, 6};
	localparam int fifo_depth = 1 << `RX_FIFO_DEPTH_LOG2;
	localparam int keep_all   = 1 << 30;

	logic                     phy_rx_clk;
	logic                     rx_rst2;
	mii_pkg::nibble_t         phy_rx_data;
	logic                     phy_dv;
	logic                     phy_rx_er;
	mii_pkg::rx_entry_t       rd_entry;
	logic                     empty;
	logic                     ack;
	logic                     fifo_full;
	frame_pkg::frame_status_t frame_status;
	logic                     frame_done;

	// Expected FIFO entries and status words in arrival order.
	mii_pkg::rx_entry_t       exp_q [$];
	frame_pkg::frame_status_t stat_q [$];

	// Separate streams for ack and payload.
	logic [15:0] ack_lfsr  = 16'd51927;
	logic [15:0] data_lfsr = 16'd51927;
	logic        hold_ack;
	int          entry_errors  = 0;
	int          status_errors = 0;
	int          check_errors  = 0;
	int          pop_count     = 0;

	mac_rx_top mac_rx_top_i (
		.phy_rx_clk   (phy_rx_clk),
		.rx_rst2      (rx_rst2),
		.phy_rx_data  (phy_rx_data),
		.phy_dv       (phy_dv),
		.phy_rx_er    (phy_rx_er),
		.rd_entry     (rd_entry),
		.empty        (empty),
		.ack          (ack),
		.fifo_full    (fifo_full),
		.frame_status (frame_status),
		.frame_done   (frame_done)
	);

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// 16-bit Galois LFSR with taps 16 14 13 11.
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
	endfunction

	// Eight payload bits with one step each.
	function automatic mii_pkg::byte_t random_byte();
		mii_pkg::byte_t b;
		for (int i = 0; i < 8; i++) begin
			b[i] = data_lfsr[0];
			data_lfsr = lfsr_next(data_lfsr);
		end
		return b;
	endfunction

	// IEEE 802.3 CRC with an MSB-first register and data bits in wire order.
	function automatic frame_pkg::crc_t crc_step(input frame_pkg::crc_t c,
		input mii_pkg::byte_t d);
		frame_pkg::crc_t r;
		logic            fb;
		r = c;
		for (int i = 0; i < 8; i++) begin
			fb = r[31] ^ d[i];
			r = {r[30:0], 1'b0} ^ (fb ? 32'h04C11DB7 : 32'h0);
		end
		return r;
	endfunction

	// FCS field is complemented and sent x^31 term first.
	function automatic frame_pkg::crc_t fcs_of(input frame_pkg::crc_t c);
		frame_pkg::crc_t f;
		for (int j = 0; j < 32; j++) begin
			f[j] = ~c[31 - j];
		end
		return f;
	endfunction

	// Wire nibbles plus 50 cycles of slack per frame and 200 more.
	function automatic int run_limit();
		int n;
		n = 200 + 1;
		for (int i = 0; i < n_frames; i++) begin
			n += 2 * (8 + payload_lens[i] + 4) + 50;
		end
		return n;
	endfunction

	task automatic drive_nibble(input mii_pkg::nibble_t n, input logic er);
		@(posedge phy_rx_clk);
		#1;
		phy_dv      = 1'b1;
		phy_rx_data = n;
		phy_rx_er   = er;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge phy_rx_clk);
			#1;
			phy_dv      = 1'b0;
			phy_rx_data = '0;
			phy_rx_er   = 1'b0;
		end
	endtask

	// Preamble, SFD, payload and FCS with optional faults.
	// Only the first keep entries survive the FIFO.
	task automatic send_frame(input int len, input int bad_byte, input int er_nibble,
		input logic odd, input int keep);
		mii_pkg::byte_t           bytes [$];
		mii_pkg::byte_t           b;
		frame_pkg::crc_t          crc;
		frame_pkg::crc_t          fcs;
		frame_pkg::frame_status_t st;
		logic                     err;
		int                       nib;
		for (int i = 0; i < 7; i++) begin
			bytes.push_back(8'h55);
		end
		bytes.push_back(8'hD5);
		crc = '1;
		for (int i = 0; i < len; i++) begin
			b = random_byte();
			bytes.push_back(b);
			crc = crc_step(crc, b);
		end
		fcs = fcs_of(crc);
		for (int k = 0; k < 4; k++) begin
			bytes.push_back(fcs[8*k +: 8]);
		end
		// Corruption goes in once the FCS is fixed.
		if (bad_byte >= 0) begin
			bytes[8 + bad_byte] = bytes[8 + bad_byte] ^ 8'hFF;
		end
		// Reference model.
		err = (er_nibble >= 0) || odd;
		foreach (bytes[i]) begin
			if (i < keep) begin
				exp_q.push_back({1'b0, bytes[i]});
			end
		end
		if (bytes.size() < keep) begin
			exp_q.push_back({1'b1, 6'b0, odd, err});
		end
		st.length     = frame_pkg::frame_len_t'(len + 4);
		st.crc_ok     = (bad_byte < 0);
		st.phy_err    = (er_nibble >= 0) && !odd;
		st.odd_nibble = odd;
		st.overflow   = (bytes.size() >= keep);
		stat_q.push_back(st);
		// Wire order with low nibble first.
		nib = 0;
		foreach (bytes[i]) begin
			b = bytes[i];
			drive_nibble(b[3:0], nib == er_nibble);
			drive_nibble(b[7:4], nib + 1 == er_nibble);
			nib += 2;
		end
		if (odd) begin
			drive_nibble(4'hA, 1'b0);
		end
		idle_cycles(12);
	endtask

	task automatic wait_drained();
		while (exp_q.size() != 0 || stat_q.size() != 0 || !empty) begin
			@(posedge phy_rx_clk);
			#1;
		end
	endtask

	task automatic print_summary();
		$display("Summary: %0d entry errors, %0d status errors, %0d other errors, %0d pops",
			entry_errors, status_errors, check_errors, pop_count);
	endtask

	//////////////////////////////
	// Processes
	//////////////////////////////

	initial begin
		phy_rx_clk = 1'b0;
		forever #50 phy_rx_clk = ~phy_rx_clk;
	end

	// Consumer acks about three cycles in four.
	initial begin
		logic go;
		ack = 1'b0;
		forever begin
			@(posedge phy_rx_clk);
			#1;
			ack = 1'b0;
			if (!rx_rst2 && !hold_ack) begin
				go = ack_lfsr[0];
				ack_lfsr = lfsr_next(ack_lfsr);
				go = go | ack_lfsr[0];
				ack_lfsr = lfsr_next(ack_lfsr);
				if (go && !empty) begin
					if (exp_q.size() == 0) begin
						entry_errors++;
						$display("ERROR at %0t: FIFO shows an entry no frame produced", $time);
					end else begin
						assert (rd_entry == exp_q[0]) else begin
							entry_errors++;
							$display("MISMATCH at %0t: rd_entry got %h expected %h",
								$time, rd_entry, exp_q[0]);
						end
						exp_q.delete(0);
					end
					pop_count++;
					ack = 1'b1;
				end
			end
		end
	end

	// Status word on every frame_done.
	initial begin
		forever begin
			@(posedge phy_rx_clk);
			#1;
			if (frame_done) begin
				if (stat_q.size() == 0) begin
					status_errors++;
					$display("ERROR at %0t: frame_done pulsed with no frame sent", $time);
				end else begin
					assert (frame_status == stat_q[0]) else begin
						status_errors++;
						$display("MISMATCH at %0t: frame_status got %h expected %h",
							$time, frame_status, stat_q[0]);
					end
					stat_q.delete(0);
				end
			end
		end
	end

	// Watchdog.
	initial begin
		int limit;
		int cycles;
		limit  = run_limit();
		cycles = 0;
		while (cycles < limit) begin
			@(posedge phy_rx_clk);
			cycles++;
		end
		$display("ERROR: run stopped after %0d cycles without finishing", cycles);
		print_summary();
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		rx_rst2     = 1'b1;
		phy_rx_data = '0;
		phy_dv      = 1'b0;
		phy_rx_er   = 1'b0;
		hold_ack    = 1'b0;
		repeat (10) @(posedge phy_rx_clk);
		#1;
		assert (empty && !fifo_full && !frame_done) else begin
			check_errors++;
			$display("ERROR at %0t: wrong state after reset", $time);
		end
		rx_rst2 = 1'b0;
		idle_cycles(2);
		// Clean frame, corrupted byte, PHY error and odd nibble.
		send_frame(payload_lens[0], -1, -1, 1'b0, keep_all);
		send_frame(payload_lens[1], 5, -1, 1'b0, keep_all);
		send_frame(payload_lens[2], -1, 2 * (8 + 3) + 1, 1'b0, keep_all);
		send_frame(payload_lens[3], -1, -1, 1'b1, keep_all);
		wait_drained();
		// Ack held low over a long frame.
		hold_ack = 1'b1;
		assert (!fifo_full) else begin
			check_errors++;
			$display("ERROR at %0t: fifo_full high with the FIFO drained", $time);
		end
		send_frame(payload_lens[4], -1, -1, 1'b0, fifo_depth);
		assert (fifo_full) else begin
			check_errors++;
			$display("ERROR at %0t: fifo_full low with %0d entries stored", $time, fifo_depth);
		end
		hold_ack = 1'b0;
		wait_drained();
		// Recovery after overflow.
		send_frame(payload_lens[5], -1, -1, 1'b0, keep_all);
		wait_drained();
		idle_cycles(4);
		print_summary();
		if (entry_errors + status_errors + check_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* sources.f */
+incdir+include
design/mii_pkg.sv
design/frame_pkg.sv
design/rx_crc32.sv
design/mii_nibble_packer.sv
design/rx_entry_fifo.sv
design/rx_frame_stats.sv
design/mac_rx_top.sv
tb/tb_mac_rx.sv

/* Makefile */
# Verilator lint and simulation of the MII receive path.
TOOL       = verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert
TOP        = tb_mac_rx
FILE_LIST  = sources.f
OBJ_DIR    = obj_dir
PASS_TEXT  = TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

# Pass only when the pass line shows up in the output.
sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
